// ==== src/mem_map_pkg.sv ====
`default_nettype none

package mem_map_pkg;

	typedef logic [15:0] addr_t;
	typedef logic [7:0]  data_t;

	typedef enum logic [2:0] {
		ROM,
		VRAM,
		WRAM0,
		WRAMX,
		OAM,
		IO,
		HRAM,
		OPEN
	} region_t;

	typedef enum logic [1:0] {
		IDLE,
		ACCESS,
		RESPOND
	} state_t;

	// region bases
	localparam addr_t VRAM_BASE  = 16'h8000;
	localparam addr_t EXT_BASE   = 16'hA000; // external ram, not present
	localparam addr_t WRAM_BASE  = 16'hC000;
	localparam addr_t WRAMX_BASE = 16'hD000;
	localparam addr_t ECHO_BASE  = 16'hE000;
	localparam addr_t OAM_BASE   = 16'hFE00;
	localparam addr_t OAM_END    = 16'hFEA0; // start of unusable area
	localparam addr_t IO_BASE    = 16'hFF00;
	localparam addr_t HRAM_BASE  = 16'hFF80;

	localparam addr_t ECHO_OFFSET = 16'h2000; // echo minus work ram

	// i/o registers kept in this design
	localparam addr_t VBK_ADDR  = 16'hFF4F;
	localparam addr_t SVBK_ADDR = 16'hFF70;
	localparam addr_t IE_ADDR   = 16'hFFFF;

	localparam data_t OPEN_BUS = 8'hFF;

	// memory geometry
	localparam int VRAM_BANKS = 2;
	localparam int WRAM_BANKS = 8;
	localparam int VRAM_DEPTH = 8192;
	localparam int WRAM_DEPTH = 4096;
	localparam int OAM_DEPTH  = 160;
	localparam int HRAM_DEPTH = 127; // FF80..FFFE, FFFF is IE

endpackage

`default_nettype wire

// ==== src/mem_access_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface mem_access_if #(
	parameter int BANK_W   = 1,
	parameter int OFFSET_W = 8
);

	logic                en;
	logic                we;
	logic [BANK_W-1:0]   bank;
	logic [OFFSET_W-1:0] offset;
	mem_map_pkg::data_t  wdata;
	mem_map_pkg::data_t  rdata; // valid one clock after en

	modport ctrl (
		output en, we, bank, offset, wdata,
		input  rdata
	);

	modport ram (
		input  en, we, bank, offset, wdata,
		output rdata
	);

endinterface

`default_nettype wire

// ==== src/region_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module region_decoder (
	input  mem_map_pkg::addr_t   addr,
	output mem_map_pkg::region_t region,
	output mem_map_pkg::addr_t   offset,
	output logic                 echo
);

	mem_map_pkg::addr_t mirror;

	assign mirror = addr - mem_map_pkg::ECHO_OFFSET; // echo folded onto work ram

	always_comb begin
		region = mem_map_pkg::OPEN;
		offset = addr;
		echo   = 1'b0;
		if (addr < mem_map_pkg::VRAM_BASE) begin
			region = mem_map_pkg::ROM; // cartridge, offset is the address
		end
		else if (addr < mem_map_pkg::EXT_BASE) begin
			region = mem_map_pkg::VRAM;
			offset = addr - mem_map_pkg::VRAM_BASE;
		end
		else if (addr < mem_map_pkg::WRAM_BASE) begin
			region = mem_map_pkg::OPEN; // no external ram fitted
			offset = addr - mem_map_pkg::EXT_BASE;
		end
		else if (addr < mem_map_pkg::WRAMX_BASE) begin
			region = mem_map_pkg::WRAM0;
			offset = addr - mem_map_pkg::WRAM_BASE;
		end
		else if (addr < mem_map_pkg::ECHO_BASE) begin
			region = mem_map_pkg::WRAMX;
			offset = addr - mem_map_pkg::WRAMX_BASE;
		end
		else if (addr < mem_map_pkg::OAM_BASE) begin
			// E nibble mirrors bank 0, F nibble the switchable bank
			echo = 1'b1;
			if (mirror < mem_map_pkg::WRAMX_BASE) begin
				region = mem_map_pkg::WRAM0;
				offset = mirror - mem_map_pkg::WRAM_BASE;
			end
			else begin
				region = mem_map_pkg::WRAMX;
				offset = mirror - mem_map_pkg::WRAMX_BASE;
			end
		end
		else if (addr < mem_map_pkg::OAM_END) begin
			region = mem_map_pkg::OAM;
			offset = addr - mem_map_pkg::OAM_BASE;
		end
		else if (addr < mem_map_pkg::IO_BASE) begin
			region = mem_map_pkg::OPEN; // unusable area
			offset = addr - mem_map_pkg::OAM_END;
		end
		else if (addr < mem_map_pkg::HRAM_BASE) begin
			region = mem_map_pkg::IO;
			offset = addr - mem_map_pkg::IO_BASE;
		end
		else if (addr == mem_map_pkg::IE_ADDR) begin
			region = mem_map_pkg::IO; // IE sits above high ram
			offset = addr - mem_map_pkg::IO_BASE;
		end
		else begin
			region = mem_map_pkg::HRAM;
			offset = addr - mem_map_pkg::HRAM_BASE;
		end
	end

endmodule

`default_nettype wire

// ==== src/bank_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module bank_regs (
	input  logic               clk4_2,
	input  logic               reset_n,
	input  logic               io_we,
	input  mem_map_pkg::data_t io_offset,
	input  mem_map_pkg::data_t wdata,
	output mem_map_pkg::data_t io_rdata,
	output logic               vram_bank,
	output logic [2:0]         wram_bank
);

	logic               vbk_q;
	logic [2:0]         svbk_q;
	mem_map_pkg::data_t ie_q;

	always_ff @(posedge clk4_2 or negedge reset_n) begin
		if (!reset_n) begin
			vbk_q  <= 1'b0;
			svbk_q <= 3'd0;
			ie_q   <= 8'h00;
		end
		else if (io_we) begin
			case (io_offset)
				mem_map_pkg::VBK_ADDR[7:0]: begin
					vbk_q <= wdata[0]; // only bit 0 is a bank select
				end
				mem_map_pkg::SVBK_ADDR[7:0]: begin
					svbk_q <= wdata[2:0];
				end
				mem_map_pkg::IE_ADDR[7:0]: begin
					ie_q <= wdata;
				end
				default: begin
				end
			endcase
		end
	end

	always_comb begin
		case (io_offset)
			mem_map_pkg::VBK_ADDR[7:0]: begin
				io_rdata = {7'b0, vbk_q};
			end
			mem_map_pkg::SVBK_ADDR[7:0]: begin
				io_rdata = {5'b0, svbk_q};
			end
			mem_map_pkg::IE_ADDR[7:0]: begin
				io_rdata = ie_q;
			end
			default: begin
				io_rdata = mem_map_pkg::OPEN_BUS; // unmapped i/o
			end
		endcase
	end

	assign vram_bank = vbk_q;
	assign wram_bank = (svbk_q == 3'd0) ? 3'd1 : svbk_q; // bank 0 is never switchable

endmodule

`default_nettype wire

// ==== src/banked_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module banked_ram #(
	parameter int NUM_BANKS = 1,
	parameter int DEPTH     = 128
) (
	input logic       clk4_2,
	mem_access_if.ram port
);

	localparam int ADDR_W = $clog2(NUM_BANKS * DEPTH);

	mem_map_pkg::data_t mem [NUM_BANKS * DEPTH];
	logic [ADDR_W-1:0]  idx;

	// banks laid end to end in one array
	assign idx = ADDR_W'(port.bank) * ADDR_W'(DEPTH) + ADDR_W'(port.offset);

	always_ff @(posedge clk4_2) begin
		if (port.en) begin
			if (port.we) begin
				mem[idx] <= port.wdata;
			end
			else begin
				port.rdata <= mem[idx]; // held until the next enabled read
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/router_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module router_ctrl (
	input  logic                 clk4_2,
	input  logic                 reset_n,
	input  logic                 req_valid,
	output logic                 req_ready,
	input  mem_map_pkg::addr_t   req_addr,
	input  logic                 req_write,
	input  mem_map_pkg::data_t   req_wdata,
	output logic                 resp_valid,
	input  logic                 resp_ready,
	output mem_map_pkg::data_t   resp_data,
	output mem_map_pkg::addr_t   rom_addr,
	input  mem_map_pkg::data_t   rom_data,
	output mem_map_pkg::addr_t   cur_addr,
	input  mem_map_pkg::region_t region,
	input  mem_map_pkg::addr_t   offset,
	input  logic                 echo,
	output logic                 io_we,
	output mem_map_pkg::data_t   io_offset,
	output mem_map_pkg::data_t   io_wdata,
	input  mem_map_pkg::data_t   io_rdata,
	input  logic                 vram_bank,
	input  logic [2:0]           wram_bank,
	mem_access_if.ctrl           vram,
	mem_access_if.ctrl           wram,
	mem_access_if.ctrl           oam,
	mem_access_if.ctrl           hram
);

	localparam int VRAM_OW = $clog2(mem_map_pkg::VRAM_DEPTH);
	localparam int WRAM_OW = $clog2(mem_map_pkg::WRAM_DEPTH);
	localparam int OAM_OW  = $clog2(mem_map_pkg::OAM_DEPTH);
	localparam int HRAM_OW = $clog2(mem_map_pkg::HRAM_DEPTH);

	mem_map_pkg::state_t  state;
	mem_map_pkg::addr_t   addr_q;
	logic                 write_q;
	mem_map_pkg::data_t   wdata_q;
	mem_map_pkg::region_t region_q;
	mem_map_pkg::data_t   rom_q;
	logic                 access;
	logic                 wr_ok;

	always_ff @(posedge clk4_2 or negedge reset_n) begin
		if (!reset_n) begin
			state <= mem_map_pkg::IDLE;
		end
		else begin
			case (state)
				mem_map_pkg::IDLE: begin
					if (req_valid) state <= mem_map_pkg::ACCESS;
				end
				mem_map_pkg::ACCESS: begin
					state <= mem_map_pkg::RESPOND;
				end
				mem_map_pkg::RESPOND: begin
					if (resp_ready) state <= mem_map_pkg::IDLE;
				end
				default: begin
					state <= mem_map_pkg::IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk4_2) begin
		if (req_valid && req_ready) begin
			addr_q  <= req_addr;
			write_q <= req_write;
			wdata_q <= req_wdata;
		end
		if (access) begin
			region_q <= region;
			rom_q    <= rom_data; // rom is combinational off rom_addr
		end
	end

	assign req_ready  = (state == mem_map_pkg::IDLE);
	assign resp_valid = (state == mem_map_pkg::RESPOND);
	assign access     = (state == mem_map_pkg::ACCESS);
	assign wr_ok      = write_q && !echo; // echo area is read only

	assign cur_addr = addr_q;
	assign rom_addr = addr_q;

	assign vram.en     = access && (region == mem_map_pkg::VRAM);
	assign vram.we     = vram.en && wr_ok;
	assign vram.bank   = vram_bank;
	assign vram.offset = offset[VRAM_OW-1:0];
	assign vram.wdata  = wdata_q;

	assign wram.en     = access && (region == mem_map_pkg::WRAM0 ||
		region == mem_map_pkg::WRAMX);
	assign wram.we     = wram.en && wr_ok;
	assign wram.bank   = (region == mem_map_pkg::WRAMX) ? wram_bank : '0;
	assign wram.offset = offset[WRAM_OW-1:0];
	assign wram.wdata  = wdata_q;

	assign oam.en     = access && (region == mem_map_pkg::OAM);
	assign oam.we     = oam.en && wr_ok;
	assign oam.bank   = '0;
	assign oam.offset = offset[OAM_OW-1:0];
	assign oam.wdata  = wdata_q;

	assign hram.en     = access && (region == mem_map_pkg::HRAM);
	assign hram.we     = hram.en && wr_ok;
	assign hram.bank   = '0;
	assign hram.offset = offset[HRAM_OW-1:0];
	assign hram.wdata  = wdata_q;

	assign io_we     = access && (region == mem_map_pkg::IO) && write_q;
	assign io_offset = offset[7:0];
	assign io_wdata  = wdata_q;

	// rams hold rdata while disabled, so this is stable through RESPOND
	always_comb begin
		case (region_q)
			mem_map_pkg::ROM:   resp_data = rom_q;
			mem_map_pkg::VRAM:  resp_data = vram.rdata;
			mem_map_pkg::WRAM0: resp_data = wram.rdata;
			mem_map_pkg::WRAMX: resp_data = wram.rdata;
			mem_map_pkg::OAM:   resp_data = oam.rdata;
			mem_map_pkg::HRAM:  resp_data = hram.rdata;
			mem_map_pkg::IO:    resp_data = io_rdata;
			default:            resp_data = mem_map_pkg::OPEN_BUS;
		endcase
	end

endmodule

`default_nettype wire

// ==== src/mem_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_router (
	input  logic               clk4_2,
	input  logic               reset_n,
	input  logic               req_valid,
	output logic               req_ready,
	input  mem_map_pkg::addr_t req_addr,
	input  logic               req_write,
	input  mem_map_pkg::data_t req_wdata,
	output logic               resp_valid,
	input  logic               resp_ready,
	output mem_map_pkg::data_t resp_data,
	output mem_map_pkg::addr_t rom_addr,
	input  mem_map_pkg::data_t rom_data
);

	localparam int VRAM_BW = $clog2(mem_map_pkg::VRAM_BANKS);
	localparam int WRAM_BW = $clog2(mem_map_pkg::WRAM_BANKS);
	localparam int VRAM_OW = $clog2(mem_map_pkg::VRAM_DEPTH);
	localparam int WRAM_OW = $clog2(mem_map_pkg::WRAM_DEPTH);
	localparam int OAM_OW  = $clog2(mem_map_pkg::OAM_DEPTH);
	localparam int HRAM_OW = $clog2(mem_map_pkg::HRAM_DEPTH);

	mem_map_pkg::addr_t   cur_addr;
	mem_map_pkg::region_t region;
	mem_map_pkg::addr_t   offset;
	logic                 echo;
	logic                 io_we;
	mem_map_pkg::data_t   io_offset;
	mem_map_pkg::data_t   io_wdata;
	mem_map_pkg::data_t   io_rdata;
	logic                 vram_bank;
	logic [2:0]           wram_bank;

	mem_access_if #(.BANK_W(VRAM_BW), .OFFSET_W(VRAM_OW)) vram_if ();
	mem_access_if #(.BANK_W(WRAM_BW), .OFFSET_W(WRAM_OW)) wram_if ();
	mem_access_if #(.BANK_W(1), .OFFSET_W(OAM_OW)) oam_if (); // single bank
	mem_access_if #(.BANK_W(1), .OFFSET_W(HRAM_OW)) hram_if ();

	router_ctrl u_ctrl (
		.clk4_2     (clk4_2),
		.reset_n    (reset_n),
		.req_valid  (req_valid),
		.req_ready  (req_ready),
		.req_addr   (req_addr),
		.req_write  (req_write),
		.req_wdata  (req_wdata),
		.resp_valid (resp_valid),
		.resp_ready (resp_ready),
		.resp_data  (resp_data),
		.rom_addr   (rom_addr),
		.rom_data   (rom_data),
		.cur_addr   (cur_addr),
		.region     (region),
		.offset     (offset),
		.echo       (echo),
		.io_we      (io_we),
		.io_offset  (io_offset),
		.io_wdata   (io_wdata),
		.io_rdata   (io_rdata),
		.vram_bank  (vram_bank),
		.wram_bank  (wram_bank),
		.vram       (vram_if.ctrl),
		.wram       (wram_if.ctrl),
		.oam        (oam_if.ctrl),
		.hram       (hram_if.ctrl)
	);

	region_decoder u_decoder (
		.addr   (cur_addr),
		.region (region),
		.offset (offset),
		.echo   (echo)
	);

	bank_regs u_bank_regs (
		.clk4_2    (clk4_2),
		.reset_n   (reset_n),
		.io_we     (io_we),
		.io_offset (io_offset),
		.wdata     (io_wdata),
		.io_rdata  (io_rdata),
		.vram_bank (vram_bank),
		.wram_bank (wram_bank)
	);

	banked_ram #(.NUM_BANKS(mem_map_pkg::VRAM_BANKS), .DEPTH(mem_map_pkg::VRAM_DEPTH))
		u_vram (.clk4_2(clk4_2), .port(vram_if.ram));

	banked_ram #(.NUM_BANKS(mem_map_pkg::WRAM_BANKS), .DEPTH(mem_map_pkg::WRAM_DEPTH))
		u_wram (.clk4_2(clk4_2), .port(wram_if.ram));

	banked_ram #(.NUM_BANKS(1), .DEPTH(mem_map_pkg::OAM_DEPTH))
		u_oam (.clk4_2(clk4_2), .port(oam_if.ram));

	banked_ram #(.NUM_BANKS(1), .DEPTH(mem_map_pkg::HRAM_DEPTH))
		u_hram (.clk4_2(clk4_2), .port(hram_if.ram));

endmodule

`default_nettype wire

// ==== tests/tb_mem_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_router;

	localparam int TIMEOUT = 20;

	logic               clk4_2;
	logic               reset_n;
	logic               req_valid;
	logic               req_ready;
	mem_map_pkg::addr_t req_addr;
	logic               req_write;
	mem_map_pkg::data_t req_wdata;
	logic               resp_valid;
	logic               resp_ready;
	mem_map_pkg::data_t resp_data;
	mem_map_pkg::addr_t rom_addr;
	mem_map_pkg::data_t rom_data;

	integer             seed = 68519;
	mem_map_pkg::data_t vram_sh [2][8192]; // shadow of the memory map
	mem_map_pkg::data_t wram_sh [8][4096];
	mem_map_pkg::data_t oam_sh [160];
	mem_map_pkg::data_t hram_sh [127];
	logic               vbk_sh = 1'b0;
	logic [2:0]         svbk_sh = 3'd0;
	mem_map_pkg::data_t ie_sh = 8'h00;
	mem_map_pkg::data_t expect_q [$];
	bit                 read_q [$];
	int                 resp_count = 0;
	logic               held = 1'b0;
	mem_map_pkg::data_t held_data;

	mem_router DUT (
		.clk4_2     (clk4_2),
		.reset_n    (reset_n),
		.req_valid  (req_valid),
		.req_ready  (req_ready),
		.req_addr   (req_addr),
		.req_write  (req_write),
		.req_wdata  (req_wdata),
		.resp_valid (resp_valid),
		.resp_ready (resp_ready),
		.resp_data  (resp_data),
		.rom_addr   (rom_addr),
		.rom_data   (rom_data)
	);

	assign rom_data = rom_addr[7:0] ^ rom_addr[15:8]; // cartridge model

	initial begin
		clk4_2 = 1'b0;
		forever #5 clk4_2 = ~clk4_2;
	end

	function automatic mem_map_pkg::addr_t pool_off(input int k, input int depth);
		return 16'(k * (depth / 16) + k % 4); // 16 spots spread over a region
	endfunction

	function automatic mem_map_pkg::data_t ref_read(input mem_map_pkg::addr_t a);
		logic [2:0]         xb;
		mem_map_pkg::addr_t o;
		xb = (svbk_sh == 3'd0) ? 3'd1 : svbk_sh;
		if (a < 16'h8000)
			return a[7:0] ^ a[15:8];
		if (a < 16'hA000) begin
			o = a - 16'h8000;
			return vram_sh[vbk_sh][o[12:0]];
		end
		if (a >= 16'hC000 && a < 16'hFE00) begin
			o = (a >= 16'hE000) ? a - 16'h2000 : a; // echo folds onto work ram
			if (o < 16'hD000)
				return wram_sh[0][o[11:0]];
			return wram_sh[xb][o[11:0]];
		end
		if (a >= 16'hFE00 && a < 16'hFEA0) begin
			o = a - 16'hFE00;
			return oam_sh[o[7:0]];
		end
		if (a == 16'hFF4F)
			return {7'b0, vbk_sh};
		if (a == 16'hFF70)
			return {5'b0, svbk_sh};
		if (a == 16'hFFFF)
			return ie_sh;
		if (a >= 16'hFF80) begin
			o = a - 16'hFF80;
			return hram_sh[o[6:0]];
		end
		return 8'hFF; // ext ram, unusable area, other i/o
	endfunction

	function automatic void shadow_write(input mem_map_pkg::addr_t a, input mem_map_pkg::data_t d);
		logic [2:0]         xb;
		mem_map_pkg::addr_t o;
		xb = (svbk_sh == 3'd0) ? 3'd1 : svbk_sh;
		o = a - 16'h8000;
		if (a >= 16'h8000 && a < 16'hA000)
			vram_sh[vbk_sh][o[12:0]] = d;
		else if (a >= 16'hC000 && a < 16'hD000)
			wram_sh[0][a[11:0]] = d;
		else if (a >= 16'hD000 && a < 16'hE000)
			wram_sh[xb][a[11:0]] = d;
		else if (a >= 16'hFE00 && a < 16'hFEA0)
			oam_sh[a[7:0]] = d;
		else if (a == 16'hFF4F)
			vbk_sh = d[0];
		else if (a == 16'hFF70)
			svbk_sh = d[2:0];
		else if (a == 16'hFFFF)
			ie_sh = d;
		else if (a >= 16'hFF80) begin
			o = a - 16'hFF80;
			hram_sh[o[6:0]] = d;
		end
	endfunction

	task automatic check_data(input mem_map_pkg::data_t got, input mem_map_pkg::data_t exp,
		input string what);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
			$display("Errors found");
			$fatal(1, "stopped at the first error");
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s, got %b, expected %b", $time, what, got, exp);
			$display("Errors found");
			$fatal(1, "stopped at the first error");
		end
	endtask

	task automatic check_addr(input mem_map_pkg::addr_t got, input mem_map_pkg::addr_t exp,
		input string what);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
			$display("Errors found");
			$fatal(1, "stopped at the first error");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Errors found");
		$fatal(1, "timed out at %0t ns waiting for %s", $time, what);
	endtask

	// one request and its response with resp_ready held low for stall cycles
	task automatic access(input mem_map_pkg::addr_t a, input logic wr,
		input mem_map_pkg::data_t d, input int stall);
		int t;
		req_addr   = a;
		req_write  = wr;
		req_wdata  = d;
		req_valid  = 1'b1;
		resp_ready = (stall == 0);
		t = 0;
		@(negedge clk4_2);
		while (!req_ready) begin
			t++;
			if (t > TIMEOUT)
				report_timeout("req_ready");
			@(negedge clk4_2);
		end
		expect_q.push_back(ref_read(a));
		read_q.push_back(!wr);
		if (wr)
			shadow_write(a, d);
		@(posedge clk4_2);
		#1;
		req_valid = 1'b0;
		t = 0;
		@(negedge clk4_2);
		if (a < 16'h8000)
			check_addr(rom_addr, a, "rom_addr in the access cycle"); // rom sampled here
		while (!resp_valid) begin
			t++;
			if (t > TIMEOUT)
				report_timeout("resp_valid");
			@(negedge clk4_2);
		end
		if (stall > 0) begin
			repeat (stall) @(posedge clk4_2);
			#1;
			resp_ready = 1'b1;
		end
		@(posedge clk4_2);
		#1;
		resp_ready = 1'b0;
	endtask

	task automatic pick_addr(output mem_map_pkg::addr_t a);
		logic [31:0] r;
		int          k;
		r = $random(seed);
		k = int'(r[11:8]);
		case (r[31:28] % 4'd12)
			4'd0: a = {1'b0, r[14:0]};
			4'd1: a = 16'h8000 + pool_off(k, 8192);
			4'd2: a = 16'hA000 + {3'b0, r[12:0]};
			4'd3: a = 16'hC000 + pool_off(k, 4096);
			4'd4: a = 16'hD000 + pool_off(k, 4096);
			4'd5: a = 16'hE000 + pool_off(k, 4096);
			4'd6: a = 16'hF000 + pool_off(k % 14, 4096); // stays below FE00
			4'd7: a = 16'hFE00 + pool_off(k, 160);
			4'd8: a = 16'hFEA0 + {9'b0, r[6:0]} % 16'h0060;
			4'd9: a = 16'hFF00 + {9'b0, r[6:0]};
			4'd10: a = r[0] ? 16'hFF4F : (r[1] ? 16'hFF70 : 16'hFFFF);
			default: a = 16'hFF80 + pool_off(k, 127);
		endcase
	endtask

	// compares every response as it transfers
	always @(negedge clk4_2) begin
		if (reset_n) begin
			if (held) begin
				check_flag(resp_valid, 1'b1, "resp_valid under back-pressure");
				check_data(resp_data, held_data, "resp_data under back-pressure");
			end
			if (resp_valid) begin
				check_flag(req_ready, 1'b0, "req_ready while a response is pending");
				if (resp_ready) begin
					check_flag(resp_count < expect_q.size(), 1'b1, "response with a request");
					if (read_q[resp_count])
						check_data(resp_data, expect_q[resp_count], "read data");
					resp_count++;
				end
			end
			held      = resp_valid && !resp_ready;
			held_data = resp_data;
		end
	end

	initial begin
		int                 k;
		int                 s;
		logic [31:0]        r;
		mem_map_pkg::addr_t a;
		reset_n    = 1'b0;
		req_valid  = 1'b0;
		req_addr   = 16'h0000;
		req_write  = 1'b0;
		req_wdata  = 8'h00;
		resp_ready = 1'b0;
		repeat (3) @(posedge clk4_2);
		#1;
		reset_n = 1'b1;
		@(negedge clk4_2);
		check_flag(req_ready, 1'b1, "req_ready after reset");
		check_flag(resp_valid, 1'b0, "resp_valid after reset");
		@(posedge clk4_2);
		#1;
		access(16'hFF4F, 1'b0, 8'h00, 0);
		access(16'hFF70, 1'b0, 8'h00, 0);
		access(16'hFFFF, 1'b0, 8'h00, 0);
		for (k = 0; k < 20; k++) begin
			r = $random(seed);
			access({1'b0, r[14:0]}, 1'b0, 8'h00, 0);
			access({8'hA2, r[23:16]}, 1'b0, 8'h00, 0);
			access(16'hFEA0 + {9'b0, r[30:24]} % 16'h0060, 1'b0, 8'h00, 0);
		end
		// fill both vram banks, oam and hram, then read back
		for (s = 0; s < 2; s++) begin
			access(16'hFF4F, 1'b1, 8'(s), 0);
			for (k = 0; k < 16; k++) begin
				r = $random(seed);
				access(16'h8000 + pool_off(k, 8192), 1'b1, r[7:0], 0);
				access(16'hFE00 + pool_off(k, 160), 1'b1, r[15:8], 0);
				access(16'hFF80 + pool_off(k, 127), 1'b1, r[23:16], 0);
			end
		end
		for (s = 0; s < 2; s++) begin
			access(16'hFF4F, 1'b1, 8'(s) | 8'hFE, 0); // upper bits not stored
			access(16'hFF4F, 1'b0, 8'h00, 0);
			for (k = 0; k < 16; k++) begin
				access(16'h8000 + pool_off(k, 8192), 1'b0, 8'h00, 0);
				access(16'hFE00 + pool_off(k, 160), 1'b0, 8'h00, 0);
				access(16'hFF80 + pool_off(k, 127), 1'b0, 8'h00, 0);
			end
		end
		r = $random(seed);
		access(16'hFFFF, 1'b1, r[7:0], 0);
		access(16'hFFFF, 1'b0, 8'h00, 0);
		// every work ram bank with svbk 0 landing on bank 1
		for (s = 0; s < 8; s++) begin
			access(16'hFF70, 1'b1, 8'(s), 0);
			for (k = 0; k < 16; k++) begin
				r = $random(seed);
				access(16'hD000 + pool_off(k, 4096), 1'b1, r[7:0], 0);
				access(16'hC000 + pool_off(k, 4096), 1'b1, r[15:8], 0);
			end
		end
		for (s = 0; s < 8; s++) begin
			access(16'hFF70, 1'b1, 8'(s) | 8'hF8, 0);
			access(16'hFF70, 1'b0, 8'h00, 0);
			for (k = 0; k < 16; k++) begin
				access(16'hD000 + pool_off(k, 4096), 1'b0, 8'h00, 0);
				access(16'hE000 + pool_off(k, 4096), 1'b0, 8'h00, 0);
				if (k < 14)
					access(16'hF000 + pool_off(k, 4096), 1'b0, 8'h00, 0);
			end
		end
		a = 16'hE000 + pool_off(2, 4096);
		access(a, 1'b1, ~ref_read(a), 0); // must not land
		access(a, 1'b0, 8'h00, 0);
		a = 16'hF000 + pool_off(5, 4096);
		access(a, 1'b1, ~ref_read(a), 0);
		access(a, 1'b0, 8'h00, 0);
		for (k = 0; k < 40; k++) begin
			pick_addr(a);
			r = $random(seed);
			access(a, 1'b0, 8'h00, 1 + int'(r[2:0]));
		end
		for (k = 0; k < 300; k++) begin
			pick_addr(a);
			r = $random(seed);
			access(a, r[8], r[7:0], int'(r[18:16]));
		end
		@(negedge clk4_2);
		if (resp_count == expect_q.size()) begin
			$display("No errors");
			$finish;
		end
		else begin
			$display("Errors found");
			$fatal(1, "%0d requests never got a response", expect_q.size() - resp_count);
		end
	end

endmodule

`default_nettype wire

// ==== list.f ====
src/mem_map_pkg.sv
src/mem_access_if.sv
src/region_decoder.sv
src/bank_regs.sv
src/banked_ram.sv
src/router_ctrl.sv
src/mem_router.sv
tests/tb_mem_router.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ps -j 0 \
	--top-module tb_mem_router -f list.f -o tb_mem_router
./obj_dir/tb_mem_router
